/* Bender.yml */
package:
  name: a09

sources:
  - include_dirs:
      - .
    files:
      - a09Pkg.sv
      - a09ProgramMem.sv
      - a09RegFile.sv
      - a09FetchStage.sv
      - a09DecodeStage.sv
      - a09ExecuteStage.sv
      - a09Top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_a09Top.sv

/* a09DecodeStage.sv */
`include "a09_macros.svh"

// Decode
// Picks the union view, reads operands, bypasses execute's write
module a09DecodeStage (
    input  logic                       pin3_clk_16mhz,
    input  logic                       rstN,
    input  logic                       stepEn,
    input  a09Pkg::fetchOutT           fetchIn,
    input  a09Pkg::redirectT           redirect,
    input  a09Pkg::regWriteT           regWr,       // Same-step write for bypass
    input  logic [`A09_DATA_WIDTH-1:0] rDataA,
    input  logic [`A09_DATA_WIDTH-1:0] rDataB,
    output a09Pkg::regAddrT            rAddrA,
    output a09Pkg::regAddrT            rAddrB,
    output a09Pkg::decodeOutT          decodeOut
);

    localparam int ImmW = $bits(fetchIn.instr.i.imm);
    localparam int ExtW = `A09_DATA_WIDTH - ImmW;

    a09Pkg::instrU              instr;
    a09Pkg::opcodeT             op;
    logic [`A09_DATA_WIDTH-1:0] valA;
    logic [`A09_DATA_WIDTH-1:0] valB;
    a09Pkg::decodeOutT          decodeNext;

    assign instr = fetchIn.instr;
    assign op    = instr.r.op;      // Opcode sits in the same bits in both views

    // ------------------------------------------------------------------
    // Operand read
    // ------------------------------------------------------------------
    always_comb begin
        case (op)
            a09Pkg::ADDI,
            a09Pkg::BNZ: rAddrA = instr.i.rd;    // rd doubles as source
            default:     rAddrA = instr.r.rs1;
        endcase
    end
    assign rAddrB = instr.r.rs2;

    // Forward execute's result, r0 never forwarded
    assign valA = (regWr.en && (rAddrA != '0) && (regWr.addr == rAddrA)) ?
                  regWr.data : rDataA;
    assign valB = (regWr.en && (rAddrB != '0) && (regWr.addr == rAddrB)) ?
                  regWr.data : rDataB;

    // ------------------------------------------------------------------
    // Slot build
    // ------------------------------------------------------------------
    always_comb begin
        decodeNext.valid  = fetchIn.valid;
        decodeNext.op     = op;
        decodeNext.rd     = instr.i.rd;
        decodeNext.opA    = valA;
        decodeNext.opB    = valB;
        decodeNext.target = instr.i.imm[`A09_ADDR_WIDTH-1:0];    // Used by BNZ/JMP
        case (op)
            a09Pkg::LDI:  decodeNext.opB = {{ExtW{1'b0}}, instr.i.imm};
            a09Pkg::ADDI: decodeNext.opB = {{ExtW{instr.i.imm[ImmW-1]}}, instr.i.imm};
            a09Pkg::NOP, a09Pkg::ADD, a09Pkg::SUB, a09Pkg::AND, a09Pkg::OR,
            a09Pkg::XOR, a09Pkg::OUT, a09Pkg::BNZ, a09Pkg::JMP,
            a09Pkg::HALT: decodeNext.op = op;   // Register operands as read
            default:      decodeNext.op = a09Pkg::NOP;   // Unknown opcode
        endcase
    end

    always_ff @(posedge pin3_clk_16mhz) begin
        if (!rstN) begin
            decodeOut.valid <= 1'b0;
        end else if (stepEn) begin
            decodeOut <= decodeNext;
            if (redirect.taken) begin
                decodeOut.valid <= 1'b0;        // Younger slot squashed
            end
        end
    end

endmodule

/* a09ExecuteStage.sv */
`include "a09_macros.svh"

// Execute
// ALU, branch resolve, write-back request, output register, halt
module a09ExecuteStage (
    input  logic                       pin3_clk_16mhz,
    input  logic                       rstN,
    input  logic                       stepEn,
    input  a09Pkg::decodeOutT          decodeIn,
    output a09Pkg::regWriteT           regWr,
    output a09Pkg::redirectT           redirect,
    output logic [`A09_DATA_WIDTH-1:0] outWord,
    output logic                       halted
);

    logic                       active;     // Slot may take effect
    logic                       writesReg;
    logic [`A09_DATA_WIDTH-1:0] result;

    // Nothing retires after HALT
    assign active = decodeIn.valid && !halted;

    // ------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------
    always_comb begin
        result    = decodeIn.opB;
        writesReg = 1'b1;
        case (decodeIn.op)
            a09Pkg::ADD:  result = decodeIn.opA + decodeIn.opB;     // Wraps
            a09Pkg::SUB:  result = decodeIn.opA - decodeIn.opB;
            a09Pkg::AND:  result = decodeIn.opA & decodeIn.opB;
            a09Pkg::OR:   result = decodeIn.opA | decodeIn.opB;
            a09Pkg::XOR:  result = decodeIn.opA ^ decodeIn.opB;
            a09Pkg::LDI:  result = decodeIn.opB;    // Immediate already extended
            a09Pkg::ADDI: result = decodeIn.opA + decodeIn.opB;
            default:      writesReg = 1'b0;         // OUT, branches, HALT, NOP
        endcase
    end

    // Write-back lands on this step's edge
    always_comb begin
        regWr.en   = stepEn && active && writesReg;
        regWr.addr = decodeIn.rd;
        regWr.data = result;
    end

    // ------------------------------------------------------------------
    // Branch resolve
    // ------------------------------------------------------------------
    always_comb begin
        redirect.target = decodeIn.target;
        redirect.taken  = 1'b0;
        if (active) begin
            case (decodeIn.op)
                a09Pkg::JMP: redirect.taken = 1'b1;
                a09Pkg::BNZ: redirect.taken = (decodeIn.opA != '0);
                default:     redirect.taken = 1'b0;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Output register and halt flag
    // ------------------------------------------------------------------
    always_ff @(posedge pin3_clk_16mhz) begin
        if (!rstN) begin
            outWord <= '0;
            halted  <= 1'b0;
        end else if (stepEn && active) begin
            if (decodeIn.op == a09Pkg::OUT) begin
                outWord <= decodeIn.opA;    // rs1 value
            end
            if (decodeIn.op == a09Pkg::HALT) begin
                halted <= 1'b1;             // Sticky until reset
            end
        end
    end

endmodule

/* a09FetchStage.sv */
`include "a09_macros.svh"

// Fetch
// PC, program read request and the fetch slot handed to decode
module a09FetchStage (
    input  logic                       pin3_clk_16mhz,
    input  logic                       rstN,
    input  logic                       stepEn,
    input  logic                       halt,        // Sticky halted from execute
    input  a09Pkg::redirectT           redirect,
    input  a09Pkg::instrU              memData,     // Registered word from memory
    output logic                       memRdEn,
    output logic [`A09_ADDR_WIDTH-1:0] memAddr,
    output a09Pkg::fetchOutT           fetchOut
);

    logic [`A09_ADDR_WIDTH-1:0] pc;
    logic [`A09_ADDR_WIDTH-1:0] pcQ;    // PC of the word now in memData
    logic                       validQ;

    // Memory read lines up with the slot register below
    assign memAddr = pc;
    assign memRdEn = stepEn && !halt;   // Freeze the word once halted

    always_ff @(posedge pin3_clk_16mhz) begin
        if (!rstN) begin
            pc     <= '0;
            pcQ    <= '0;
            validQ <= 1'b0;
        end else if (stepEn) begin
            if (halt) begin
                validQ <= 1'b0;             // PC frozen, bubbles only
            end else if (redirect.taken) begin
                pc     <= redirect.target;  // Word read this step is wrong path
                validQ <= 1'b0;
            end else begin
                pc     <= pc + 1'b1;
                pcQ    <= pc;
                validQ <= 1'b1;
            end
        end
    end

    // Slot pairs the memory's output register with its PC
    assign fetchOut.valid = validQ;
    assign fetchOut.pc    = pcQ;
    assign fetchOut.instr = memData;

endmodule

/* a09Pkg.sv */
`include "a09_macros.svh"

package a09Pkg;

    // ------------------------------------------------------------------
    // Instruction encoding
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        AND  = 4'd3,
        OR   = 4'd4,
        XOR  = 4'd5,
        LDI  = 4'd6,            // rd = zext(imm)
        ADDI = 4'd7,            // rd = rd + sext(imm)
        OUT  = 4'd8,            // outWord = rs1
        BNZ  = 4'd9,            // Branch to imm if rd != 0
        JMP  = 4'd10,
        HALT = 4'd15
    } opcodeT;                  // Unlisted codes behave as NOP

    typedef logic [$clog2(`A09_REG_COUNT)-1:0] regAddrT;

    // Three-register form
    typedef struct packed {
        opcodeT  op;
        regAddrT rd;
        regAddrT rs1;
        regAddrT rs2;
    } regFormT;

    // Register plus 8-bit immediate
    typedef struct packed {
        opcodeT     op;
        regAddrT    rd;
        logic [7:0] imm;
    } immFormT;

    // One instruction word, two views
    typedef union packed {
        regFormT r;
        immFormT i;
    } instrU;

    // ------------------------------------------------------------------
    // Stage-to-stage bundles
    // ------------------------------------------------------------------
    typedef struct packed {
        logic                       valid;
        logic [`A09_ADDR_WIDTH-1:0] pc;     // Address the word came from
        instrU                      instr;
    } fetchOutT;

    typedef struct packed {
        logic                       valid;
        opcodeT                     op;     // Already folded to NOP if unknown
        regAddrT                    rd;
        logic [`A09_DATA_WIDTH-1:0] opA;    // Bypassed operands
        logic [`A09_DATA_WIDTH-1:0] opB;
        logic [`A09_ADDR_WIDTH-1:0] target; // Branch / jump destination
    } decodeOutT;

    // Execute back to fetch and decode
    typedef struct packed {
        logic                       taken;
        logic [`A09_ADDR_WIDTH-1:0] target;
    } redirectT;

    // Execute to register file and decode bypass
    typedef struct packed {
        logic                       en;
        regAddrT                    addr;
        logic [`A09_DATA_WIDTH-1:0] data;
    } regWriteT;

endpackage

/* a09ProgramMem.sv */
`include "a09_macros.svh"

// 256-word instruction store
// Host writes through we, fetch reads one registered word per step
module a09ProgramMem (
    input  logic                       pin3_clk_16mhz,
    input  logic                       we,          // Host write strobe
    input  logic [`A09_ADDR_WIDTH-1:0] wAddr,
    input  logic [`A09_DATA_WIDTH-1:0] wData,
    input  logic                       rdEn,        // Fetch read enable
    input  logic [`A09_ADDR_WIDTH-1:0] rAddr,
    output a09Pkg::instrU              rData
);

    localparam int Depth = 1 << `A09_ADDR_WIDTH;

    logic [`A09_DATA_WIDTH-1:0] mem [Depth];

    // Write port, one word per clock
    always_ff @(posedge pin3_clk_16mhz) begin
        if (we) begin
            mem[wAddr] <= wData;
        end
    end

    // Read register holds while fetch is stalled
    always_ff @(posedge pin3_clk_16mhz) begin
        if (rdEn) begin
            rData <= a09Pkg::instrU'(mem[rAddr]);
        end
    end

endmodule

/* a09RegFile.sv */
`include "a09_macros.svh"

// 16 x 16 register file
// Two async read ports, one write port, r0 hardwired to zero
module a09RegFile (
    input  logic                       pin3_clk_16mhz,
    input  logic                       rstN,
    input  a09Pkg::regAddrT            rAddrA,
    input  a09Pkg::regAddrT            rAddrB,
    input  a09Pkg::regWriteT           wr,          // Already step-qualified
    output logic [`A09_DATA_WIDTH-1:0] rDataA,
    output logic [`A09_DATA_WIDTH-1:0] rDataB
);

    logic [`A09_DATA_WIDTH-1:0] regs [`A09_REG_COUNT];

    always_ff @(posedge pin3_clk_16mhz) begin
        if (!rstN) begin
            for (int i = 0; i < `A09_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && (wr.addr != '0)) begin   // Drop writes to r0
            regs[wr.addr] <= wr.data;
        end
    end

    // r0 never written, so it always reads back zero
    assign rDataA = regs[rAddrA];
    assign rDataB = regs[rAddrB];

endmodule

/* a09Top.sv */
`include "a09_macros.svh"

// A09 core top
// Step divider, heartbeat and the three-stage pipeline
// Board uses outWord[7:0] for the LEDs
module a09Top #(
    parameter int StepDiv = `A09_STEP_DIV   // Board clocks per step
) (
    input  logic                       pin3_clk_16mhz,
    input  logic                       rstN,
    input  logic                       progWe,      // Host load, core in reset
    input  logic [`A09_ADDR_WIDTH-1:0] progAddr,
    input  logic [`A09_DATA_WIDTH-1:0] progData,
    output logic [`A09_DATA_WIDTH-1:0] outWord,
    output logic                       halted,
    output logic                       heartbeat    // Toggles every step
);

    localparam int CntW = (StepDiv > 1) ? $clog2(StepDiv) : 1;

    logic [CntW-1:0]            stepCnt;
    logic                       stepEn;
    logic                       memRdEn;
    logic [`A09_ADDR_WIDTH-1:0] memAddr;
    a09Pkg::instrU              memData;
    a09Pkg::regAddrT            rAddrA;
    a09Pkg::regAddrT            rAddrB;
    logic [`A09_DATA_WIDTH-1:0] rDataA;
    logic [`A09_DATA_WIDTH-1:0] rDataB;
    a09Pkg::fetchOutT           fetchOut;
    a09Pkg::decodeOutT          decodeOut;
    a09Pkg::redirectT           redirect;
    a09Pkg::regWriteT           regWr;

    // ------------------------------------------------------------------
    // Step enable and heartbeat
    // ------------------------------------------------------------------
    assign stepEn = (stepCnt == CntW'(StepDiv - 1));    // One clock in StepDiv

    always_ff @(posedge pin3_clk_16mhz) begin
        if (!rstN) begin
            stepCnt   <= '0;
            heartbeat <= 1'b0;
        end else if (stepEn) begin
            stepCnt   <= '0;
            heartbeat <= ~heartbeat;
        end else begin
            stepCnt <= stepCnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Pipeline
    // ------------------------------------------------------------------
    a09ProgramMem uProgMem (
        .pin3_clk_16mhz(pin3_clk_16mhz), .we(progWe), .wAddr(progAddr),
        .wData(progData), .rdEn(memRdEn), .rAddr(memAddr), .rData(memData)
    );

    a09RegFile uRegFile (
        .pin3_clk_16mhz(pin3_clk_16mhz), .rstN(rstN), .rAddrA(rAddrA),
        .rAddrB(rAddrB), .wr(regWr), .rDataA(rDataA), .rDataB(rDataB)
    );

    a09FetchStage uFetch (
        .pin3_clk_16mhz(pin3_clk_16mhz), .rstN(rstN), .stepEn(stepEn),
        .halt(halted), .redirect(redirect), .memData(memData),
        .memRdEn(memRdEn), .memAddr(memAddr), .fetchOut(fetchOut)
    );

    a09DecodeStage uDecode (
        .pin3_clk_16mhz(pin3_clk_16mhz), .rstN(rstN), .stepEn(stepEn),
        .fetchIn(fetchOut), .redirect(redirect), .regWr(regWr),
        .rDataA(rDataA), .rDataB(rDataB), .rAddrA(rAddrA), .rAddrB(rAddrB),
        .decodeOut(decodeOut)
    );

    a09ExecuteStage uExecute (
        .pin3_clk_16mhz(pin3_clk_16mhz), .rstN(rstN), .stepEn(stepEn),
        .decodeIn(decodeOut), .regWr(regWr), .redirect(redirect),
        .outWord(outWord), .halted(halted)
    );

endmodule

/* a09_macros.svh */
`ifndef A09_MACROS_SVH
`define A09_MACROS_SVH

// ---------------------------------------------------------------------
// Core sizing
// ---------------------------------------------------------------------
`define A09_DATA_WIDTH 16       // Data and instruction word
`define A09_ADDR_WIDTH 8        // Program address, 256 words
`define A09_REG_COUNT  16       // General registers, r0 reads zero

// ---------------------------------------------------------------------
// Stepping
// ---------------------------------------------------------------------
// Board clocks per pipeline step
// 16 MHz / 16M gives about one step per second on the board
`define A09_STEP_DIV 16000000

`endif

/* tb_a09Top.sv */
`include "a09_macros.svh"

// Directed testbench for the A09 core, one step per clock
module tb_a09Top;

    localparam int ClkPeriod   = 100;
    localparam int DriveDelay  = 10;        // Inputs change this long after the edge
    localparam int ResetCycles = 10;
    localparam int HaltTimeout = 2000;      // Cycles allowed per program
    localparam int HoldCycles  = 20;        // Watch window after halt
    localparam int MemDepth    = 1 << `A09_ADDR_WIDTH;

    logic                       pin3_clk_16mhz;
    logic                       rstN;
    logic                       progWe;
    logic [`A09_ADDR_WIDTH-1:0] progAddr;
    logic [`A09_DATA_WIDTH-1:0] progData;
    logic [`A09_DATA_WIDTH-1:0] outWord;
    logic                       halted;
    logic                       heartbeat;

    logic [`A09_DATA_WIDTH-1:0] progWords [$];     // Program for the next load
    logic [`A09_DATA_WIDTH-1:0] outTrace [$];      // outWord changes seen in the last run
    int                         errCount;
    int                         checkCount;
    int                         testCount;
    int                         testFailCount;
    integer                     seed;

    a09Top #(.StepDiv(1)) u_dut (
        .pin3_clk_16mhz(pin3_clk_16mhz), .rstN(rstN), .progWe(progWe),
        .progAddr(progAddr), .progData(progData), .outWord(outWord),
        .halted(halted), .heartbeat(heartbeat)
    );

    initial begin
        pin3_clk_16mhz = 1'b0;
        forever #(ClkPeriod / 2) pin3_clk_16mhz = ~pin3_clk_16mhz;
    end

    // ------------------------------------------------------------------
    // Encoding and reference model
    // ------------------------------------------------------------------
    function automatic logic [15:0] encReg(input a09Pkg::opcodeT op, input logic [3:0] rd,
                                           input logic [3:0] rs1, input logic [3:0] rs2);
        return {op, rd, rs1, rs2};              // op | rd | rs1 | rs2
    endfunction

    function automatic logic [15:0] encImm(input a09Pkg::opcodeT op, input logic [3:0] rd,
                                           input logic [7:0] imm);
        return {op, rd, imm};                   // op | rd | imm
    endfunction

    function automatic logic [15:0] encOut(input logic [3:0] rs);
        return encReg(a09Pkg::OUT, 4'd0, rs, 4'd0);
    endfunction

    function automatic logic [15:0] sext8(input logic [7:0] imm);
        return {{8{imm[7]}}, imm};
    endfunction

    // 16-bit ALU, sums wrap
    function automatic logic [15:0] aluModel(input a09Pkg::opcodeT op,
                                             input logic [15:0] a, input logic [15:0] b);
        case (op)
            a09Pkg::ADD: return a + b;
            a09Pkg::SUB: return a - b;
            a09Pkg::AND: return a & b;
            a09Pkg::OR:  return a | b;
            a09Pkg::XOR: return a ^ b;
            default:     return 16'h0000;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Drive, check and run helpers
    // ------------------------------------------------------------------
    task automatic nextEdge;
        @(posedge pin3_clk_16mhz);
        #DriveDelay;                            // Outputs settled, safe to drive
    endtask

    task automatic checkValue(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    // Hold reset, then write progWords and HALT fill
    task automatic loadProgram;
        logic [8:0] addr;
        rstN = 1'b0;
        for (int i = 0; i < ResetCycles; i++) begin
            nextEdge;
        end
        for (addr = 0; addr < MemDepth; addr++) begin
            progWe   = 1'b1;
            progAddr = addr[7:0];
            if (addr < progWords.size()) begin
                progData = progWords[addr];
            end else begin
                progData = encImm(a09Pkg::HALT, 4'd0, addr[7:0]);   // HALT tagged by address
            end
            nextEdge;
        end
        progWe = 1'b0;
    endtask

    task automatic runToHalt(output bit ok);
        int          cycles;
        logic [15:0] lastOut;
        cycles  = 0;
        ok      = 1'b0;
        outTrace.delete();
        lastOut = outWord;
        rstN    = 1'b1;
        while ((halted !== 1'b1) && (cycles < HaltTimeout)) begin
            nextEdge;
            cycles++;
            if (outWord !== lastOut) begin      // Log every OUT that lands
                outTrace.push_back(outWord);
                lastOut = outWord;
            end
        end
        if (halted === 1'b1) begin
            ok = 1'b1;
        end else begin
            errCount++;
            $display("ERROR: the core never halted within %0d cycles", HaltTimeout);
        end
    endtask

    task automatic finishTest(input string name, input int errBefore);
        testCount++;
        if (errCount != errBefore) begin
            testFailCount++;
            $display("Test %0d %s: FAIL (%0d errors)", testCount, name, errCount - errBefore);
        end else begin
            $display("Test %0d %s: PASS", testCount, name);
        end
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    task automatic testResetLdi;
        int errBefore;
        bit ok;
        errBefore = errCount;
        progWords.delete();
        progWords.push_back(encImm(a09Pkg::LDI, 4'd3, 8'hC7));
        progWords.push_back(encOut(4'd3));
        progWords.push_back(encImm(a09Pkg::HALT, 4'd0, 8'h00));
        loadProgram;
        checkValue("outWord", outWord, 16'h0000);      // Still in reset
        checkValue("halted", {15'b0, halted}, 16'h0000);
        runToHalt(ok);
        if (ok) checkValue("outWord", outWord, 16'h00C7);
        finishTest("reset and LDI", errBefore);
    endtask

    // Every op consumes the result right before it
    task automatic testAluChain;
        int          errBefore;
        bit          ok;
        logic [15:0] r1;
        logic [15:0] r2;
        logic [15:0] r3;
        logic [15:0] r4;
        logic [15:0] r5;
        logic [15:0] r6;
        logic [15:0] r7;
        errBefore = errCount;
        r1 = 16'h00A5;
        r2 = 16'h003C;
        r3 = aluModel(a09Pkg::ADD, r1, r2);
        r4 = aluModel(a09Pkg::SUB, r3, r1);
        r5 = aluModel(a09Pkg::AND, r4, r2);
        r6 = aluModel(a09Pkg::OR, r5, r3);
        r7 = aluModel(a09Pkg::XOR, r6, r1);
        progWords.delete();
        progWords.push_back(encImm(a09Pkg::LDI, 4'd1, r1[7:0]));
        progWords.push_back(encImm(a09Pkg::LDI, 4'd2, r2[7:0]));
        progWords.push_back(encReg(a09Pkg::ADD, 4'd3, 4'd1, 4'd2));
        progWords.push_back(encReg(a09Pkg::SUB, 4'd4, 4'd3, 4'd1));
        progWords.push_back(encReg(a09Pkg::AND, 4'd5, 4'd4, 4'd2));
        progWords.push_back(encReg(a09Pkg::OR, 4'd6, 4'd5, 4'd3));
        progWords.push_back(encReg(a09Pkg::XOR, 4'd7, 4'd6, 4'd1));
        progWords.push_back(encOut(4'd7));
        progWords.push_back(encImm(a09Pkg::HALT, 4'd0, 8'h00));
        loadProgram;
        runToHalt(ok);
        if (ok) checkValue("outWord", outWord, r7);
        finishTest("dependent ALU chain", errBefore);
    endtask

    task automatic testImmediate;
        int errBefore;
        bit ok;
        errBefore = errCount;
        progWords.delete();
        progWords.push_back(encImm(a09Pkg::LDI, 4'd1, 8'h50));
        progWords.push_back(encImm(a09Pkg::ADDI, 4'd1, 8'hF0));   // Minus 16
        progWords.push_back(encOut(4'd1));
        progWords.push_back(encImm(a09Pkg::HALT, 4'd0, 8'h00));
        loadProgram;
        runToHalt(ok);
        if (ok) checkValue("outWord", outWord, 16'h0050 + sext8(8'hF0));
        // r0 must ignore the write
        progWords.delete();
        progWords.push_back(encImm(a09Pkg::LDI, 4'd2, 8'h33));
        progWords.push_back(encOut(4'd2));
        progWords.push_back(encImm(a09Pkg::ADDI, 4'd0, 8'hF0));
        progWords.push_back(encOut(4'd0));
        progWords.push_back(encImm(a09Pkg::HALT, 4'd0, 8'h00));
        loadProgram;
        runToHalt(ok);
        if (ok) checkValue("outWord", outWord, 16'h0000);
        finishTest("ADDI and r0", errBefore);
    endtask

    task automatic testBranch;
        int errBefore;
        bit ok;
        errBefore = errCount;
        // Countdown from 5, r2 counts iterations
        progWords.delete();
        progWords.push_back(encImm(a09Pkg::LDI, 4'd1, 8'd5));
        progWords.push_back(encImm(a09Pkg::LDI, 4'd2, 8'd0));
        progWords.push_back(encImm(a09Pkg::ADDI, 4'd2, 8'h01));   // Loop head, addr 2
        progWords.push_back(encImm(a09Pkg::ADDI, 4'd1, 8'hFF));
        progWords.push_back(encImm(a09Pkg::BNZ, 4'd1, 8'd2));
        progWords.push_back(encOut(4'd2));
        progWords.push_back(encImm(a09Pkg::HALT, 4'd0, 8'h00));
        loadProgram;
        runToHalt(ok);
        if (ok) checkValue("outWord", outWord, 16'd5);
        // Shadow slots of the JMP hold poison outputs
        progWords.delete();
        progWords.push_back(encImm(a09Pkg::LDI, 4'd1, 8'h12));
        progWords.push_back(encImm(a09Pkg::LDI, 4'd4, 8'hAD));
        progWords.push_back(encImm(a09Pkg::JMP, 4'd0, 8'd6));
        progWords.push_back(encOut(4'd4));
        progWords.push_back(encOut(4'd4));
        progWords.push_back(encOut(4'd4));
        progWords.push_back(encImm(a09Pkg::ADDI, 4'd1, 8'h01));   // Target, addr 6
        progWords.push_back(encOut(4'd1));
        progWords.push_back(encImm(a09Pkg::HALT, 4'd0, 8'h00));
        loadProgram;
        runToHalt(ok);
        if (ok) begin
            checkValue("outWord", outWord, 16'h0013);
            // Only the target's OUT may reach outWord
            checkValue("outWord updates", 16'(outTrace.size()), 16'd1);
        end
        finishTest("branch and flush", errBefore);
    endtask

    task automatic testRandomAlu;
        int             errBefore;
        bit             ok;
        logic [31:0]    r;
        logic [7:0]     a;
        logic [7:0]     b;
        logic [3:0]     rd;
        a09Pkg::opcodeT op;
        errBefore = errCount;
        for (int i = 0; i < 20; i++) begin
            r  = $random(seed);
            a  = r[7:0];
            b  = r[15:8];
            op = a09Pkg::opcodeT'(4'(1 + (r[23:16] % 5)));     // ADD through XOR
            rd = 4'(1 + (r[27:24] % 15));                    // Never r0
            progWords.delete();
            progWords.push_back(encImm(a09Pkg::LDI, 4'd1, a));
            progWords.push_back(encImm(a09Pkg::LDI, 4'd2, b));
            progWords.push_back(encReg(op, rd, 4'd1, 4'd2));
            progWords.push_back(encOut(rd));
            progWords.push_back(encImm(a09Pkg::HALT, 4'd0, 8'h00));
            loadProgram;
            runToHalt(ok);
            if (ok) begin
                checkValue($sformatf("outWord[prog %0d]", i), outWord,
                           aluModel(op, {8'h00, a}, {8'h00, b}));
            end
        end
        finishTest("random ALU", errBefore);
    endtask

    task automatic testHaltHold;
        int   errBefore;
        bit   ok;
        logic hbExpected;
        errBefore = errCount;
        progWords.delete();
        progWords.push_back(encImm(a09Pkg::LDI, 4'd1, 8'h11));
        progWords.push_back(encImm(a09Pkg::LDI, 4'd2, 8'h22));
        progWords.push_back(encOut(4'd1));
        progWords.push_back(encImm(a09Pkg::HALT, 4'd0, 8'h00));
        progWords.push_back(encOut(4'd2));                        // Must never retire
        loadProgram;
        runToHalt(ok);
        if (ok) begin
            hbExpected = heartbeat;
            for (int i = 0; i < HoldCycles; i++) begin
                nextEdge;
                hbExpected = ~hbExpected;               // Steps go on while halted
                checkValue("outWord", outWord, 16'h0011);
                checkValue("halted", {15'b0, halted}, 16'h0001);
                checkValue("heartbeat", {15'b0, heartbeat}, {15'b0, hbExpected});
            end
        end
        finishTest("halt hold", errBefore);
    endtask

    // ------------------------------------------------------------------
    // Sequence
    // ------------------------------------------------------------------
    initial begin
        rstN          = 1'b0;
        progWe        = 1'b0;
        progAddr      = '0;
        progData      = '0;
        seed          = 32'h6b8c_961b;
        errCount      = 0;
        checkCount    = 0;
        testCount     = 0;
        testFailCount = 0;

        testResetLdi;
        testAluChain;
        testImmediate;
        testBranch;
        testRandomAlu;
        testHaltHold;

        $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 testCount, testFailCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
a09Pkg.sv
a09ProgramMem.sv
a09RegFile.sv
a09FetchStage.sv
a09DecodeStage.sv
a09ExecuteStage.sv
a09Top.sv
tb_a09Top.sv
